// ==== hw/racing_pkg.sv ====
package racing_pkg;

  // car bitmap geometry
  localparam int SPRITE_ROWS  = 16;
  localparam int SPRITE_WIDTH = 8;

  // raster counter, wide enough for a 309-clock line and a 262-line frame
  typedef logic [8:0] video_pos_t;

  // on-screen object coordinate
  typedef logic [7:0] coord_t;

  // player velocity, the upper nibble sets scroll rate
  typedef logic [7:0] speed_t;

  // distance travelled along the track
  typedef logic [15:0] track_pos_t;

  // one row of the car bitmap, msb is the leftmost pixel
  typedef logic [SPRITE_WIDTH-1:0] bitmap_row_t;

  // row index into the car bitmap
  typedef logic [$clog2(SPRITE_ROWS)-1:0] row_index_t;

  // sprite renderer FSM states
  typedef enum logic [2:0] {
    wait_vstart,
    wait_load,
    load_setup,
    load_fetch,
    wait_hstart,
    draw
  } sprite_state_e;

endpackage

// ==== hw/video_timing_if.sv ====
`timescale 1ns/100ps

interface video_timing_if;

  // raster position of the current pixel
  racing_pkg::video_pos_t hpos;
  racing_pkg::video_pos_t vpos;

  // high inside the 256x240 active area
  logic display_on;

  // sync levels, before output registering
  logic hsync;
  logic vsync;

  // single-cycle strobes
  logic line_start;
  logic frame_start;

  modport source (
    output hpos, vpos, display_on, hsync, vsync, line_start, frame_start
  );

  modport sink (
    input hpos, vpos, display_on, hsync, vsync, line_start, frame_start
  );

endinterface

// ==== hw/hvsync_generator.sv ====
`timescale 1ns/100ps

module hvsync_generator #(
  parameter int H_DISPLAY = 256,
  parameter int H_FRONT   = 7,
  parameter int H_SYNC    = 23,
  parameter int H_BACK    = 23,
  parameter int V_DISPLAY = 240,
  parameter int V_BOTTOM  = 14,
  parameter int V_SYNC    = 3,
  parameter int V_TOP     = 5
) (
  input  logic            clk,
  input  logic            arst_n,
  video_timing_if.source  timing
);

  localparam int H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP;
  localparam int H_SYNC_START = H_DISPLAY + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC - 1;
  localparam int V_SYNC_START = V_DISPLAY + V_BOTTOM;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC - 1;

  racing_pkg::video_pos_t hcount;
  racing_pkg::video_pos_t vcount;
  logic                   h_last;
  logic                   v_last;

  assign h_last = (hcount == racing_pkg::video_pos_t'(H_TOTAL - 1));
  assign v_last = (vcount == racing_pkg::video_pos_t'(V_TOTAL - 1));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hcount <= '0;
      vcount <= '0;
    end
    else if (h_last)
    begin
      hcount <= '0;
      // vertical counter only moves at the end of a line
      vcount <= v_last ? '0 : vcount + 1'b1;
    end
    else
    begin
      hcount <= hcount + 1'b1;
    end
  end

  assign timing.hpos        = hcount;
  assign timing.vpos        = vcount;
  assign timing.display_on  = (hcount < racing_pkg::video_pos_t'(H_DISPLAY)) &&
                              (vcount < racing_pkg::video_pos_t'(V_DISPLAY));
  assign timing.hsync       = (hcount >= racing_pkg::video_pos_t'(H_SYNC_START)) &&
                              (hcount <= racing_pkg::video_pos_t'(H_SYNC_END));
  assign timing.vsync       = (vcount >= racing_pkg::video_pos_t'(V_SYNC_START)) &&
                              (vcount <= racing_pkg::video_pos_t'(V_SYNC_END));
  assign timing.line_start  = (hcount == '0);
  // first clock of the vsync pulse
  assign timing.frame_start = (hcount == '0) &&
                              (vcount == racing_pkg::video_pos_t'(V_SYNC_START));

endmodule

// ==== hw/car_rom_arbiter.sv ====
`timescale 1ns/100ps

module car_rom_arbiter #(
  parameter int LOAD_START = 256,
  parameter int LOAD_SPLIT = 260
) (
  video_timing_if.sink            timing,
  output logic                    player_load,
  output logic                    enemy_load,
  input  racing_pkg::row_index_t  player_addr,
  input  racing_pkg::row_index_t  enemy_addr,
  output racing_pkg::bitmap_row_t rom_bits
);

  racing_pkg::row_index_t rom_addr;

  // player fetches first in hblank, the enemy takes the rest of the line
  assign player_load = (timing.hpos >= racing_pkg::video_pos_t'(LOAD_START)) &&
                       (timing.hpos < racing_pkg::video_pos_t'(LOAD_SPLIT));
  assign enemy_load  = (timing.hpos >= racing_pkg::video_pos_t'(LOAD_SPLIT));

  assign rom_addr = player_load ? player_addr : enemy_addr;

  // car seen from above, nose at row 0
  always_comb
  begin
    case (rom_addr)
      4'd0:    rom_bits = 8'b00001100;
      4'd1:    rom_bits = 8'b11001100;
      4'd2:    rom_bits = 8'b11111100;
      4'd3:    rom_bits = 8'b11101100;
      4'd4:    rom_bits = 8'b11100000;
      4'd5:    rom_bits = 8'b01100000;
      4'd6:    rom_bits = 8'b01110000;
      4'd7:    rom_bits = 8'b00110000;
      4'd8:    rom_bits = 8'b00110000;
      4'd9:    rom_bits = 8'b00110000;
      4'd10:   rom_bits = 8'b01101110;
      4'd11:   rom_bits = 8'b11101110;
      4'd12:   rom_bits = 8'b11111110;
      4'd13:   rom_bits = 8'b11101110;
      4'd14:   rom_bits = 8'b00001110;
      default: rom_bits = 8'b00001110;
    endcase
  end

endmodule

// ==== hw/sprite_renderer.sv ====
`timescale 1ns/100ps

module sprite_renderer (
  input  logic                    clk,
  input  logic                    arst_n,
  video_timing_if.sink            timing,
  input  racing_pkg::coord_t      x,
  input  racing_pkg::coord_t      y,
  input  logic                    load,
  output racing_pkg::row_index_t  rom_addr,
  input  racing_pkg::bitmap_row_t rom_bits,
  output logic                    gfx,
  output logic                    in_progress
);

  localparam int PX_BITS = $clog2(racing_pkg::SPRITE_WIDTH);

  typedef logic [PX_BITS-1:0] px_index_t;

  racing_pkg::sprite_state_e state;
  racing_pkg::row_index_t    row_count;
  px_index_t                 px_count;
  racing_pkg::bitmap_row_t   pix_bits;
  logic                      vstart;
  logic                      hstart;
  logic                      shifting;
  logic                      px_last;
  logic                      row_last;

  assign vstart   = (timing.vpos == racing_pkg::video_pos_t'(y));
  assign hstart   = (timing.hpos == racing_pkg::video_pos_t'(x));
  assign px_last  = (px_count == px_index_t'(racing_pkg::SPRITE_WIDTH - 1));
  assign row_last = (row_count == racing_pkg::row_index_t'(racing_pkg::SPRITE_ROWS - 1));

  // first pixel leaves in the hstart cycle itself, so x maps straight to hpos
  assign shifting = (state == racing_pkg::draw) ||
                    ((state == racing_pkg::wait_hstart) && hstart);
  assign gfx      = shifting && pix_bits[racing_pkg::SPRITE_WIDTH-1];

  assign in_progress = (state != racing_pkg::wait_vstart);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= racing_pkg::wait_vstart;
      row_count <= '0;
      px_count  <= '0;
    end
    else
    begin
      case (state)
        racing_pkg::wait_vstart:
        begin
          row_count <= '0;
          if (vstart)
            state <= racing_pkg::wait_load;
        end
        racing_pkg::wait_load:
          if (load)
            state <= racing_pkg::load_setup;
        racing_pkg::load_setup:
          state <= racing_pkg::load_fetch;
        racing_pkg::load_fetch:
          state <= racing_pkg::wait_hstart;
        racing_pkg::wait_hstart:
          if (hstart)
          begin
            px_count <= px_index_t'(1);
            state    <= racing_pkg::draw;
          end
        racing_pkg::draw:
        begin
          px_count <= px_count + 1'b1;
          if (px_last)
          begin
            row_count <= row_count + 1'b1;
            state     <= row_last ? racing_pkg::wait_vstart : racing_pkg::wait_load;
          end
        end
        default:
          state <= racing_pkg::wait_vstart;
      endcase
    end
  end

  // row address and pixel shifter
  always_ff @(posedge clk)
  begin
    if (state == racing_pkg::load_setup)
      rom_addr <= row_count;
    if (state == racing_pkg::load_fetch)
      pix_bits <= rom_bits;
    else if (shifting)
      pix_bits <= pix_bits << 1;
  end

endmodule

// ==== hw/game_state.sv ====
`timescale 1ns/100ps

module game_state #(
  parameter int PLAYER_ROW  = 180,
  parameter int ENEMY_LEFT  = 64,
  parameter int ENEMY_RIGHT = 192
) (
  input  logic                   clk,
  input  logic                   arst_n,
  video_timing_if.sink           timing,
  input  logic                   hpaddle,
  input  logic                   vpaddle,
  input  logic                   collision,
  output racing_pkg::coord_t     player_x,
  output racing_pkg::coord_t     player_y,
  output racing_pkg::coord_t     enemy_x,
  output racing_pkg::coord_t     enemy_y,
  output racing_pkg::track_pos_t track_pos
);

  racing_pkg::coord_t paddle_x;
  racing_pkg::coord_t paddle_y;
  racing_pkg::speed_t speed;
  logic               enemy_dir;
  logic               frame_collision;
  logic               enemy_hit_edge;

  // paddle timers are read as the line on which the input went low
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      paddle_x <= '0;
      paddle_y <= '0;
    end
    else if (timing.line_start)
    begin
      if (!hpaddle)
        paddle_x <= timing.vpos[7:0];
      if (!vpaddle)
        paddle_y <= timing.vpos[7:0];
    end
  end

  // sticky over the whole frame, cleared when the frame update uses it
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      frame_collision <= 1'b0;
    else if (timing.frame_start)
      frame_collision <= 1'b0;
    else if (collision)
      frame_collision <= 1'b1;
  end

  assign enemy_hit_edge = (enemy_x == racing_pkg::coord_t'(ENEMY_LEFT)) ||
                          (enemy_x == racing_pkg::coord_t'(ENEMY_RIGHT));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      player_x  <= '0;
      player_y  <= racing_pkg::coord_t'(PLAYER_ROW);
      enemy_x   <= 8'd128;
      enemy_y   <= 8'd128;
      enemy_dir <= 1'b0;
      track_pos <= '0;
      speed     <= 8'd31;
    end
    else if (timing.frame_start)
    begin
      player_x  <= paddle_x;
      player_y  <= racing_pkg::coord_t'(PLAYER_ROW);
      track_pos <= track_pos + {12'b0, speed[7:4]};
      // enemy drifts down the screen at the scroll rate
      enemy_y   <= enemy_y + {4'b0, speed[7:4]};
      if (enemy_hit_edge)
        enemy_dir <= ~enemy_dir;
      // dir 1 moves right; on an edge hit the step already goes the new way
      if (enemy_dir ^ enemy_hit_edge)
        enemy_x <= enemy_x + 1'b1;
      else
        enemy_x <= enemy_x - 1'b1;
      if (frame_collision)
        speed <= 8'd16;
      else if (speed < ~paddle_y)
        speed <= speed + 1'b1;
      else
        speed <= speed - 1'b1;
    end
  end

endmodule

// ==== hw/pixel_mixer.sv ====
`timescale 1ns/100ps

module pixel_mixer (
  input  logic                   clk,
  input  logic                   arst_n,
  video_timing_if.sink           timing,
  input  racing_pkg::track_pos_t track_pos,
  input  logic                   player_gfx,
  input  logic                   enemy_gfx,
  output logic                   collision,
  output logic                   hsync,
  output logic                   vsync,
  output logic [2:0]             rgb
);

  logic track_offside;
  logic track_shoulder;
  logic track_gfx;
  logic r;
  logic g;
  logic b;

  // grass on the outer columns, striped to show scrolling
  assign track_offside  = (timing.hpos[7:5] == 3'd0) || (timing.hpos[7:5] == 3'd7);
  assign track_shoulder = (timing.hpos[7:3] == 5'd3) || (timing.hpos[7:3] == 5'd28);
  assign track_gfx      = track_offside && (timing.vpos[5:1] != track_pos[5:1]);

  // player touching the enemy or running off the road
  assign collision = player_gfx && (enemy_gfx || track_gfx);

  assign r = timing.display_on && (player_gfx || enemy_gfx || track_shoulder);
  assign g = timing.display_on && (player_gfx || track_gfx);
  assign b = timing.display_on && (enemy_gfx || track_shoulder);

  // sync delayed with the colour so both leave aligned
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb   <= '0;
    end
    else
    begin
      hsync <= timing.hsync;
      vsync <= timing.vsync;
      rgb   <= {b, g, r};
    end
  end

endmodule

// ==== hw/racing_game_top.sv ====
`timescale 1ns/100ps

module racing_game_top #(
  parameter int H_DISPLAY   = 256,
  parameter int H_FRONT     = 7,
  parameter int H_SYNC      = 23,
  parameter int H_BACK      = 23,
  parameter int V_DISPLAY   = 240,
  parameter int V_BOTTOM    = 14,
  parameter int V_SYNC      = 3,
  parameter int V_TOP       = 5,
  parameter int PLAYER_ROW  = 180,
  parameter int ENEMY_LEFT  = 64,
  parameter int ENEMY_RIGHT = 192,
  parameter int LOAD_START  = 256,
  parameter int LOAD_SPLIT  = 260
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       hpaddle,
  input  logic       vpaddle,
  output logic       hsync,
  output logic       vsync,
  output logic [2:0] rgb
);

  video_timing_if timing ();

  // shared ROM link
  logic                    player_load;
  logic                    enemy_load;
  racing_pkg::row_index_t  player_addr;
  racing_pkg::row_index_t  enemy_addr;
  racing_pkg::bitmap_row_t rom_bits;

  // object positions
  racing_pkg::coord_t      player_x;
  racing_pkg::coord_t      player_y;
  racing_pkg::coord_t      enemy_x;
  racing_pkg::coord_t      enemy_y;
  racing_pkg::track_pos_t  track_pos;

  logic                    player_gfx;
  logic                    enemy_gfx;
  logic                    collision;

  hvsync_generator #(
    .H_DISPLAY (H_DISPLAY), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
    .V_DISPLAY (V_DISPLAY), .V_BOTTOM (V_BOTTOM), .V_SYNC (V_SYNC), .V_TOP (V_TOP)
  ) hvsync_gen (
    .clk (clk), .arst_n (arst_n), .timing (timing.source)
  );

  car_rom_arbiter #(.LOAD_START (LOAD_START), .LOAD_SPLIT (LOAD_SPLIT)) car_rom (
    .timing (timing.sink), .player_load (player_load), .enemy_load (enemy_load),
    .player_addr (player_addr), .enemy_addr (enemy_addr), .rom_bits (rom_bits)
  );

  sprite_renderer player_renderer (
    .clk (clk), .arst_n (arst_n), .timing (timing.sink), .x (player_x), .y (player_y),
    .load (player_load), .rom_addr (player_addr), .rom_bits (rom_bits),
    .gfx (player_gfx), .in_progress ()
  );

  sprite_renderer enemy_renderer (
    .clk (clk), .arst_n (arst_n), .timing (timing.sink), .x (enemy_x), .y (enemy_y),
    .load (enemy_load), .rom_addr (enemy_addr), .rom_bits (rom_bits),
    .gfx (enemy_gfx), .in_progress ()
  );

  game_state #(
    .PLAYER_ROW (PLAYER_ROW), .ENEMY_LEFT (ENEMY_LEFT), .ENEMY_RIGHT (ENEMY_RIGHT)
  ) game (
    .clk (clk), .arst_n (arst_n), .timing (timing.sink), .hpaddle (hpaddle),
    .vpaddle (vpaddle), .collision (collision), .player_x (player_x),
    .player_y (player_y), .enemy_x (enemy_x), .enemy_y (enemy_y), .track_pos (track_pos)
  );

  pixel_mixer mixer (
    .clk (clk), .arst_n (arst_n), .timing (timing.sink), .track_pos (track_pos),
    .player_gfx (player_gfx), .enemy_gfx (enemy_gfx), .collision (collision),
    .hsync (hsync), .vsync (vsync), .rgb (rgb)
  );

endmodule

// ==== testbench/racing_game_ref.svh ====
`ifndef RACING_GAME_REF_SVH
`define RACING_GAME_REF_SVH

// car bitmap, nose at row 0, msb is the leftmost pixel
function automatic logic [7:0] car_row(input int row);
  logic [7:0] rows [16];
  rows = '{8'h0c, 8'hcc, 8'hfc, 8'hec, 8'he0, 8'h60, 8'h70, 8'h30,
           8'h30, 8'h30, 8'h6e, 8'hee, 8'hfe, 8'hee, 8'h0e, 8'h0e};
  return rows[row];
endfunction

// striped grass on the two outer 32-pixel columns
function automatic logic track_pixel(input int h, input int v,
                                     input racing_pkg::track_pos_t tp);
  logic [8:0] hh;
  logic [8:0] vv;
  logic       offside;
  hh      = h[8:0];
  vv      = v[8:0];
  offside = (hh[7:5] == 3'd0) || (hh[7:5] == 3'd7);
  return offside && (vv[5:1] != tp[5:1]);
endfunction

function automatic logic shoulder_pixel(input int h);
  logic [8:0] hh;
  hh = h[8:0];
  return (hh[7:3] == 5'd3) || (hh[7:3] == 5'd28);
endfunction

// colour order on the pins is {b,g,r}
function automatic logic [2:0] pixel_colour(input logic display, input logic pg,
                                            input logic eg, input logic tg,
                                            input logic sh);
  logic r;
  logic g;
  logic b;
  r = pg | eg | sh;
  g = pg | tg;
  b = eg | sh;
  return display ? {b, g, r} : 3'b000;
endfunction

// one game step, applied at the start of vsync
function automatic void frame_update(inout racing_pkg::coord_t px, inout racing_pkg::coord_t py,
                                     inout racing_pkg::coord_t ex, inout racing_pkg::coord_t ey,
                                     inout logic dir, inout racing_pkg::track_pos_t tp,
                                     inout racing_pkg::speed_t sp, input logic crashed,
                                     input racing_pkg::coord_t padx,
                                     input racing_pkg::coord_t pady);
  logic hit;
  hit = (ex == 8'd64) || (ex == 8'd192);
  px  = padx;
  py  = 8'd180;
  tp  = tp + {12'b0, sp[7:4]};
  ey  = ey + {4'b0, sp[7:4]};
  ex  = (dir ^ hit) ? ex + 8'd1 : ex - 8'd1;
  dir = dir ^ hit;
  if (crashed)
    sp = 8'd16;
  else if (sp < ~pady)
    sp = sp + 8'd1;
  else
    sp = sp - 8'd1;
endfunction

`endif

// ==== testbench/racing_game_tb.sv ====
`timescale 1ns/100ps

module racing_game_tb;

  localparam int H_TOTAL  = 309;
  localparam int V_TOTAL  = 262;
  localparam int HS_FIRST = 263;
  localparam int HS_LAST  = 285;
  localparam int VS_FIRST = 254;
  localparam int VS_LAST  = 256;
  localparam int FRAMES   = 6;

  logic       clk;
  logic       arst_n;
  logic       hpaddle;
  logic       vpaddle;
  logic       hsync;
  logic       vsync;
  logic [2:0] rgb;

  // raster position of the pixel whose outputs are visible now
  int ph;
  int pv;
  int hline;
  int vline;
  logic [31:0] lfsr_state;
  logic hp_cur;
  logic vp_cur;

  // game model
  racing_pkg::coord_t     m_px;
  racing_pkg::coord_t     m_py;
  racing_pkg::coord_t     m_ex;
  racing_pkg::coord_t     m_ey;
  racing_pkg::coord_t     m_padx;
  racing_pkg::coord_t     m_pady;
  racing_pkg::track_pos_t m_tp;
  racing_pkg::speed_t     m_sp;
  logic                   m_dir;
  logic                   m_flag;

  // sprite model state of the player (index 0) and the enemy (index 1)
  logic sp_busy [2];
  logic sp_line [2];
  int   sp_row [2];

  `include "racing_game_ref.svh"

  racing_game_top DUT (
    .clk (clk), .arst_n (arst_n), .hpaddle (hpaddle), .vpaddle (vpaddle),
    .hsync (hsync), .vsync (vsync), .rgb (rgb)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic lfsr_bit();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb)
      lfsr_state = lfsr_state ^ 32'hA300_0000;
    return lsb;
  endfunction

  function automatic int random_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++)
      val = (val << 1) | int'(lfsr_bit());
    return val;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rgb(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
      report_failure($sformatf("ERR t=%0t %s exp=%0h got=%0h at h=%0d v=%0d",
                               $time, name, exp, got, ph, pv));
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("ERR t=%0t %s exp=%0b got=%0b at h=%0d v=%0d",
                               $time, name, exp, got, ph, pv));
  endtask

  task automatic check_frame(input string name, input racing_pkg::coord_t got,
                             input racing_pkg::coord_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR t=%0t %s exp=%0d got=%0d", $time, name, exp, got));
  endtask

  // arms on line y and draws row r on line y+1+r at columns x to x+7
  task automatic sprite_step(input int idx, input racing_pkg::coord_t x,
                             input racing_pkg::coord_t y, output logic gfx);
    int off;
    logic [7:0] bits;
    off = ph - int'(x);
    gfx = 1'b0;
    if (!sp_busy[idx] && pv == int'(y))
    begin
      sp_busy[idx] = 1'b1;
      sp_row[idx]  = 0;
      sp_line[idx] = 1'b0;
    end
    if (sp_busy[idx] && sp_line[idx] && off >= 0 && off < 8)
    begin
      bits = car_row(sp_row[idx]);
      gfx  = bits[7 - off];
      if (off == 7)
      begin
        sp_row[idx]++;
        if (sp_row[idx] == 16)
          sp_busy[idx] = 1'b0;
      end
    end
    // a row is fetched in hblank of every busy line
    if (ph == H_TOTAL - 1)
      sp_line[idx] = sp_busy[idx];
  endtask

  task automatic model_pixel(input logic hp, input logic vp);
    logic pg;
    logic eg;
    logic tg;
    logic col;
    logic [2:0] exp_rgb;
    sprite_step(0, m_px, m_py, pg);
    sprite_step(1, m_ex, m_ey, eg);
    tg      = track_pixel(ph, pv, m_tp);
    col     = pg && (eg || tg);
    exp_rgb = pixel_colour(ph < 256 && pv < 240, pg, eg, tg, shoulder_pixel(ph));
    check_rgb("rgb", rgb, exp_rgb);
    check_sync("hsync", hsync, ph >= HS_FIRST && ph <= HS_LAST);
    check_sync("vsync", vsync, pv >= VS_FIRST && pv <= VS_LAST);
    if (ph == 0 && pv == VS_FIRST)
    begin
      frame_update(m_px, m_py, m_ex, m_ey, m_dir, m_tp, m_sp, m_flag, m_padx, m_pady);
      m_flag = 1'b0;
      check_frame("player_x", DUT.player_x, m_px);
      check_frame("enemy_x", DUT.enemy_x, m_ex);
      check_frame("enemy_y", DUT.enemy_y, m_ey);
    end
    else if (col)
      m_flag = 1'b1;
    if (ph == 0)
    begin
      if (!hp)
        m_padx = racing_pkg::coord_t'(pv);
      if (!vp)
        m_pady = racing_pkg::coord_t'(pv);
    end
  endtask

  // drive the next pixel's inputs and then check the current one
  task automatic step_pixel();
    int nh;
    int nv;
    logic hp_next;
    logic vp_next;
    nh = (ph == H_TOTAL - 1) ? 0 : ph + 1;
    nv = (ph == H_TOTAL - 1) ? ((pv == V_TOTAL - 1) ? 0 : pv + 1) : pv;
    @(posedge clk);
    #1;
    if (nh == 0 && nv == 255)
    begin
      hline = 16 + (random_bits(8) % 184);
      vline = random_bits(8);
    end
    hp_next = (nv != hline);
    vp_next = (nv != vline);
    hpaddle = hp_next;
    vpaddle = vp_next;
    @(negedge clk);
    model_pixel(hp_cur, vp_cur);
    hp_cur = hp_next;
    vp_cur = vp_next;
    ph = nh;
    pv = nv;
  endtask

  initial
  begin
    int waited;
    arst_n      = 1'b0;
    hpaddle     = 1'b1;
    vpaddle     = 1'b1;
    hp_cur      = 1'b1;
    vp_cur      = 1'b1;
    lfsr_state  = 32'd75667;
    hline       = 300;
    vline       = 300;
    ph          = 0;
    pv          = 0;
    m_px        = 8'd0;
    m_py        = 8'd180;
    m_ex        = 8'd128;
    m_ey        = 8'd128;
    m_dir       = 1'b0;
    m_tp        = '0;
    m_sp        = 8'd31;
    m_padx      = 8'd0;
    m_pady      = 8'd0;
    m_flag      = 1'b0;
    for (int i = 0; i < 2; i++)
    begin
      sp_busy[i] = 1'b0;
      sp_line[i] = 1'b0;
      sp_row[i]  = 0;
    end
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // run up to the first registered vsync edge
    waited = 0;
    while (vsync !== 1'b1 && waited < 2 * H_TOTAL * V_TOTAL)
    begin
      step_pixel();
      waited++;
    end
    if (vsync !== 1'b1)
      report_failure("timeout while waiting for the first vsync pulse");
    if (ph != 1 || pv != VS_FIRST)
      report_failure("first vsync pulse came at the wrong raster position");

    repeat (FRAMES * H_TOTAL * V_TOTAL) step_pixel();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== racing_game.f ====
+incdir+testbench
hw/racing_pkg.sv
hw/video_timing_if.sv
hw/hvsync_generator.sv
hw/car_rom_arbiter.sv
hw/sprite_renderer.sv
hw/game_state.sv
hw/pixel_mixer.sv
hw/racing_game_top.sv
testbench/racing_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the racing game testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=racing_game_sim

verilator --binary --timing --top-module racing_game_tb -f racing_game.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

# the log decides the result
grep -q "^NO ERRORS$" "$LOG"
if [ $? -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0
